// ==== sim.f ====
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
verif/coreTb.sv

// ==== run.sh ====
#!/bin/bash
# builds the core testbench with Verilator, runs it and looks for the pass line
verilator --binary --timing --assert -f sim.f --top-module coreTb -o coreSim &&
	./obj_dir/coreSim | tee /dev/stderr | grep -qx "NO ERRORS" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// ==== verif/coreStim.txt ====
# T <test number>, then I <byte address> <instruction word>, both hex
# then W <register> <value in hex>, one per write-back in program order
T 1
I 00 20010036 # addi $1, $0, 0x36
I 04 2002fff9 # addi $2, $0, -7
I 08 00221820 # add  $3, $1, $2
I 0c 00412022 # sub  $4, $2, $1
I 10 00812824 # and  $5, $4, $1
I 14 00a23025 # or   $6, $5, $2
I 18 0083382a # slt  $7, $4, $3
I 1c 0064402a # slt  $8, $3, $4
I 20 08000008 # j    0x20
W 1 00000036
W 2 fffffff9
W 3 0000002f
W 4 ffffffc3
W 5 00000002
W 6 fffffffb
W 7 00000001
W 8 00000000
T 2
I 00 20010010 # addi $1, $0, 0x10
I 04 2002ff9c # addi $2, $0, -100
I 08 ac220004 # sw   $2, 4($1)
I 0c 8c230004 # lw   $3, 4($1)
I 10 00612020 # add  $4, $3, $1
I 14 ac040008 # sw   $4, 8($0)
I 18 8c050008 # lw   $5, 8($0)
I 1c 00a23022 # sub  $6, $5, $2
I 20 08000008 # j    0x20
W 1 00000010
W 2 ffffff9c
W 3 ffffff9c
W 4 ffffffac
W 5 ffffffac
W 6 00000010
T 3
I 00 20010007 # addi $1, $0, 7
I 04 20020007 # addi $2, $0, 7
I 08 10220001 # beq  $1, $2, +1 taken
I 0c 20030001 # addi $3, $0, 1 skipped
I 10 20030002 # addi $3, $0, 2
I 14 10610001 # beq  $3, $1, +1 not taken
I 18 2004ffff # addi $4, $0, -1
I 1c 20850001 # addi $5, $4, 1
I 20 10a00001 # beq  $5, $0, +1 taken
I 24 20060009 # addi $6, $0, 9 skipped
I 28 20060003 # addi $6, $0, 3
I 2c 0800000b # j    0x2c
W 1 00000007
W 2 00000007
W 3 00000002
W 4 ffffffff
W 5 00000000
W 6 00000003
T 4
I 00 20010001 # addi $1, $0, 1
I 04 08000004 # j    0x10
I 08 20010005 # addi $1, $0, 5 skipped
I 0c 20020005 # addi $2, $0, 5 skipped
I 10 0c000008 # jal  0x20
I 14 20030004 # addi $3, $0, 4 flushed
I 20 03e12020 # add  $4, $31, $1
I 24 08000009 # j    0x24
W 1 00000001
W 31 00000014
W 4 00000015

// ==== verif/coreTb.sv ====
`timescale 1ns/10ps

module coreTb;

	logic clk;
	logic reset;
	logic [mipsPkg::dataWidth-1:0] instrAddr;
	logic [mipsPkg::dataWidth-1:0] instr;
	logic wbValid;
	logic [mipsPkg::regAddrWidth-1:0] wbReg;
	logic [mipsPkg::dataWidth-1:0] wbData;

	// instruction memory behind the fetch port
	logic [mipsPkg::dataWidth-1:0] progMem [256];

	// stim file contents, flattened over all tests
	int testNums [$];
	int instrBase [$];
	int wbBase [$];
	logic [mipsPkg::dataWidth-1:0] instrAddrs [$];
	logic [mipsPkg::dataWidth-1:0] instrWords [$];
	logic [mipsPkg::regAddrWidth-1:0] wbRegs [$];
	logic [mipsPkg::dataWidth-1:0] wbVals [$];

	int curTest;
	int curWbBase;
	int curWbCount;
	int wbSeen;
	int checkErrors;
	int passCount;
	int failCount;
	bit stimOk;
	longint watchdogNs;

	mipsCore i_mipsCore (
		.clk(clk),
		.reset(reset),
		.instrAddr(instrAddr),
		.instr(instr),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	// unlisted words read back as nop
	assign instr = (instrAddr[31:10] == '0) ? progMem[instrAddr[9:2]] : '0;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// write-back monitor
	//////////////////////////////////////////////////
	always @(posedge clk) begin
		if (!reset) begin
			wbSeen <= 0;
		end else if (wbValid) begin
			assert (wbSeen < curWbCount) else begin
				$display("test %0d wrote register %0d after its last expected write-back",
					curTest, wbReg);
				checkErrors++;
			end
			if (wbSeen < curWbCount) begin
				assert (wbReg == wbRegs[curWbBase + wbSeen]) else begin
					$display("Fail wbReg exp %h got %h", wbRegs[curWbBase + wbSeen], wbReg);
					checkErrors++;
				end
				assert (wbData == wbVals[curWbBase + wbSeen]) else begin
					$display("Fail wbData exp %h got %h", wbVals[curWbBase + wbSeen], wbData);
					checkErrors++;
				end
			end
			wbSeen <= wbSeen + 1;
		end
	end

	task automatic readStim(output bit ok);
		int fd;
		int code;
		int num;
		int regNum;
		logic [mipsPkg::dataWidth-1:0] first;
		logic [mipsPkg::dataWidth-1:0] second;
		string line;
		ok = 1'b0;
		fd = $fopen("verif/coreStim.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/coreStim.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				// comment and blank lines fall through to default
				case (line.getc(0))
					"T": begin
						code = $sscanf(line, "T %d", num);
						testNums.push_back(num);
						instrBase.push_back(instrAddrs.size());
						wbBase.push_back(wbRegs.size());
					end
					"I": begin
						code = $sscanf(line, "I %h %h", first, second);
						instrAddrs.push_back(first);
						instrWords.push_back(second);
					end
					"W": begin
						code = $sscanf(line, "W %d %h", regNum, second);
						wbRegs.push_back(5'(regNum));
						wbVals.push_back(second);
					end
					default: ;
				endcase
			end
			$fclose(fd);
			ok = (testNums.size() > 0);
		end
	endtask

	//////////////////////////////////////////////////
	// one test: reset, load program, wait for write-backs
	//////////////////////////////////////////////////
	task automatic runTest(input int k);
		int firstInstr;
		int endInstr;
		int endWb;
		int errorsBefore;
		int resetErrors;
		int i;
		logic [mipsPkg::dataWidth-1:0] addr;
		firstInstr = instrBase[k];
		endInstr = (k + 1 < testNums.size()) ? instrBase[k + 1] : instrAddrs.size();
		endWb = (k + 1 < testNums.size()) ? wbBase[k + 1] : wbRegs.size();
		resetErrors = 0;
		@(posedge clk);
		reset <= 1'b0;
		for (i = 0; i < $size(progMem); i++) begin
			progMem[i] <= '0;
		end
		for (i = firstInstr; i < endInstr; i++) begin
			addr = instrAddrs[i];
			progMem[addr[9:2]] <= instrWords[i];
		end
		curTest = testNums[k];
		curWbBase = wbBase[k];
		curWbCount = endWb - wbBase[k];
		errorsBefore = checkErrors;
		repeat (2) @(posedge clk);
		// core state right before reset is released
		assert (instrAddr == '0) else begin
			$display("Fail instrAddr exp %h got %h", 32'h0, instrAddr);
			resetErrors++;
		end
		assert (wbValid == 1'b0) else begin
			$display("Fail wbValid exp %h got %h", 1'b0, wbValid);
			resetErrors++;
		end
		reset <= 1'b1;
		while (wbSeen < curWbCount) begin
			@(negedge clk);
		end
		// program spins in its closing j, any further write-back is stray
		repeat (6) @(negedge clk);
		if (checkErrors - errorsBefore + resetErrors == 0) begin
			$display("test %0d passed, %0d write-backs checked", curTest, curWbCount);
			passCount++;
		end else begin
			$display("test %0d failed with %0d mismatches", curTest,
				checkErrors - errorsBefore + resetErrors);
			failCount++;
		end
	endtask

	initial begin
		int k;
		reset = 1'b0;
		curTest = 0;
		curWbBase = 0;
		curWbCount = 0;
		checkErrors = 0;
		passCount = 0;
		failCount = 0;
		watchdogNs = 0;
		for (k = 0; k < $size(progMem); k++) begin
			progMem[k] <= '0;
		end
		readStim(stimOk);
		if (!stimOk) begin
			$display("no tests could be read from the stim file");
			failCount++;
		end else begin
			// instructions plus 8 per test, 6 cycles each at 40 ns
			watchdogNs = longint'(instrAddrs.size() + 8 * testNums.size()) * 6 * 40;
			for (k = 0; k < testNums.size(); k++) begin
				runTest(k);
			end
		end
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (watchdogNs > 0);
		#(watchdogNs);
		$display("watchdog expired while test %0d was still waiting for write-backs",
			curTest);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verilog/mipsCore.sv ====
`timescale 1ns/10ps

module mipsCore (
	input logic clk,
	input logic reset,
	output logic [mipsPkg::dataWidth-1:0] instrAddr,
	input logic [mipsPkg::dataWidth-1:0] instr,
	output logic wbValid,
	output logic [mipsPkg::regAddrWidth-1:0] wbReg,
	output logic [mipsPkg::dataWidth-1:0] wbData
);

	// fetch and decode
	logic [mipsPkg::dataWidth-1:0] idInstr;
	logic [mipsPkg::dataWidth-1:0] idPcPlus4;
	logic stall;
	logic redirect;
	logic [mipsPkg::dataWidth-1:0] redirectPc;
	logic [mipsPkg::regAddrWidth-1:0] rsAddr;
	logic [mipsPkg::regAddrWidth-1:0] rtAddr;
	logic [mipsPkg::dataWidth-1:0] rsData;
	logic [mipsPkg::dataWidth-1:0] rtData;

	// decode/execute register
	logic [mipsPkg::regAddrWidth-1:0] exRs, exRt, exRd;
	logic [mipsPkg::dataWidth-1:0] exRsVal, exRtVal, exImm, exPcPlus4;
	mipsPkg::functT exFunct;
	logic exAluSrc, exIsRtype, exIsLink, exRegWriteOut, exMemReadOut, exMemWrite;
	mipsPkg::wbSelT exWbSel;
	logic [mipsPkg::regAddrWidth-1:0] exDest;
	logic exRegWrite;
	logic exMemRead;

	// execute/memory register
	logic [mipsPkg::dataWidth-1:0] memResultOut, memStoreData, memPcPlus4;
	logic [mipsPkg::regAddrWidth-1:0] memDestOut;
	logic memRegWriteOut, memMemRead, memMemWrite;
	mipsPkg::wbSelT memWbSel;
	logic [mipsPkg::regAddrWidth-1:0] memDest;
	logic memRegWrite;
	logic [mipsPkg::dataWidth-1:0] memResult;

	// write-back
	logic [mipsPkg::regAddrWidth-1:0] wbDest;
	logic wbRegWrite;

	assign wbValid = wbRegWrite;
	assign wbReg = wbDest;

	fetchStage i_fetchStage (.*);

	decodeStage i_decodeStage (.*);

	regFile i_regFile (
		.*,
		.wrEnable(wbRegWrite),
		.wrAddr(wbDest),
		.wrData(wbData)
	);

	executeStage i_executeStage (.*);

	memoryStage i_memoryStage (.*);

endmodule

// ==== verilog/memoryStage.sv ====
`timescale 1ns/10ps

module memoryStage (
	input logic clk,
	input logic reset,
	input logic [mipsPkg::dataWidth-1:0] memResultOut,
	input logic [mipsPkg::dataWidth-1:0] memStoreData,
	input logic [mipsPkg::regAddrWidth-1:0] memDestOut,
	input logic memRegWriteOut,
	input logic memMemRead,
	input logic memMemWrite,
	input mipsPkg::wbSelT memWbSel,
	input logic [mipsPkg::dataWidth-1:0] memPcPlus4,
	output logic [mipsPkg::regAddrWidth-1:0] memDest,
	output logic memRegWrite,
	output logic [mipsPkg::dataWidth-1:0] memResult,
	output logic [mipsPkg::regAddrWidth-1:0] wbDest,
	output logic wbRegWrite,
	output logic [mipsPkg::dataWidth-1:0] wbData
);

	logic [mipsPkg::dataWidth-1:0] dmem [mipsPkg::dmemWords];
	logic [mipsPkg::dmemIndexWidth-1:0] wordIndex;
	logic [mipsPkg::dataWidth-1:0] loadData;

	// word addressed, byte offset ignored
	assign wordIndex = memResultOut[mipsPkg::dmemIndexWidth+1:2];
	assign loadData = memMemRead ? dmem[wordIndex] : '0;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < mipsPkg::dmemWords; i++) begin
				dmem[i] <= '0;
			end
		end else if (memMemWrite) begin
			dmem[wordIndex] <= memStoreData;
		end
	end

	// final result of this instruction, also the forwarding value
	always_comb begin
		case (memWbSel)
			mipsPkg::wbMem: memResult = loadData;
			mipsPkg::wbLink: memResult = memPcPlus4;
			default: memResult = memResultOut;
		endcase
	end

	assign memDest = memDestOut;
	assign memRegWrite = memRegWriteOut;

	//////////////////////////////////////////////////
	// memory/write-back register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wbRegWrite <= 1'b0;
		end else begin
			wbRegWrite <= memRegWriteOut && (memDestOut != '0);
		end
	end

	always_ff @(posedge clk) begin
		wbDest <= memDestOut;
		wbData <= memResult;
	end

endmodule

// ==== verilog/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
	input logic clk,
	input logic reset,
	// from decode
	input logic [mipsPkg::regAddrWidth-1:0] exRs,
	input logic [mipsPkg::regAddrWidth-1:0] exRt,
	input logic [mipsPkg::dataWidth-1:0] exRsVal,
	input logic [mipsPkg::dataWidth-1:0] exRtVal,
	input logic [mipsPkg::dataWidth-1:0] exImm,
	input logic [mipsPkg::dataWidth-1:0] exPcPlus4,
	input logic [mipsPkg::regAddrWidth-1:0] exRd,
	input mipsPkg::functT exFunct,
	input logic exAluSrc,
	input logic exIsRtype,
	input logic exIsLink,
	input logic exRegWriteOut,
	input logic exMemReadOut,
	input logic exMemWrite,
	input mipsPkg::wbSelT exWbSel,
	// forwarding sources
	input logic [mipsPkg::regAddrWidth-1:0] memDest,
	input logic memRegWrite,
	input logic [mipsPkg::dataWidth-1:0] memResult,
	input logic [mipsPkg::regAddrWidth-1:0] wbDest,
	input logic wbRegWrite,
	input logic [mipsPkg::dataWidth-1:0] wbData,
	// back to decode
	output logic [mipsPkg::regAddrWidth-1:0] exDest,
	output logic exRegWrite,
	output logic exMemRead,
	// execute/memory register
	output logic [mipsPkg::dataWidth-1:0] memResultOut,
	output logic [mipsPkg::dataWidth-1:0] memStoreData,
	output logic [mipsPkg::regAddrWidth-1:0] memDestOut,
	output logic memRegWriteOut,
	output logic memMemRead,
	output logic memMemWrite,
	output mipsPkg::wbSelT memWbSel,
	output logic [mipsPkg::dataWidth-1:0] memPcPlus4
);

	logic [mipsPkg::dataWidth-1:0] opA;
	logic [mipsPkg::dataWidth-1:0] opB;
	logic [mipsPkg::dataWidth-1:0] aluB;
	logic [mipsPkg::dataWidth-1:0] aluResult;
	mipsPkg::aluCtrlT aluCtrl;

	// youngest producer wins, wb dest 0 is already dropped upstream
	function automatic logic [mipsPkg::dataWidth-1:0] fwdValue(
		input logic [mipsPkg::regAddrWidth-1:0] src,
		input logic [mipsPkg::dataWidth-1:0] regVal
	);
		if (memRegWrite && memDest != '0 && memDest == src) begin
			return memResult;
		end else if (wbRegWrite && wbDest == src) begin
			return wbData;
		end
		return regVal;
	endfunction

	always_comb begin
		opA = fwdValue(exRs, exRsVal);
		opB = fwdValue(exRt, exRtVal);
	end

	//////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////
	// addi, lw and sw all add
	always_comb begin
		aluCtrl = mipsPkg::aluAdd;
		if (exIsRtype) begin
			case (exFunct)
				mipsPkg::fnSub: aluCtrl = mipsPkg::aluSub;
				mipsPkg::fnAnd: aluCtrl = mipsPkg::aluAnd;
				mipsPkg::fnOr: aluCtrl = mipsPkg::aluOr;
				mipsPkg::fnSlt: aluCtrl = mipsPkg::aluSlt;
				default: aluCtrl = mipsPkg::aluAdd;
			endcase
		end
	end

	assign aluB = exAluSrc ? exImm : opB;

	always_comb begin
		case (aluCtrl)
			mipsPkg::aluAnd: aluResult = opA & aluB;
			mipsPkg::aluOr: aluResult = opA | aluB;
			mipsPkg::aluSub: aluResult = opA - aluB;
			mipsPkg::aluSlt: aluResult = {{(mipsPkg::dataWidth-1){1'b0}},
				($signed(opA) < $signed(aluB))};
			default: aluResult = opA + aluB;
		endcase
	end

	// jal links to r31, R-type writes rd, the rest write rt
	always_comb begin
		if (exIsLink) begin
			exDest = mipsPkg::linkReg;
		end else if (exIsRtype) begin
			exDest = exRd;
		end else begin
			exDest = exRt;
		end
	end

	assign exRegWrite = exRegWriteOut;
	assign exMemRead = exMemReadOut;

	//////////////////////////////////////////////////
	// execute/memory register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			memRegWriteOut <= 1'b0;
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
			memWbSel <= mipsPkg::wbAlu;
		end else begin
			memRegWriteOut <= exRegWriteOut;
			memMemRead <= exMemReadOut;
			memMemWrite <= exMemWrite;
			memWbSel <= exWbSel;
		end
	end

	always_ff @(posedge clk) begin
		memResultOut <= aluResult;
		memStoreData <= opB;
		memDestOut <= exDest;
		memPcPlus4 <= exPcPlus4;
	end

endmodule

// ==== verilog/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
	input logic clk,
	input logic reset,
	// from fetch
	input logic [mipsPkg::dataWidth-1:0] idInstr,
	input logic [mipsPkg::dataWidth-1:0] idPcPlus4,
	// register file
	output logic [mipsPkg::regAddrWidth-1:0] rsAddr,
	output logic [mipsPkg::regAddrWidth-1:0] rtAddr,
	input logic [mipsPkg::dataWidth-1:0] rsData,
	input logic [mipsPkg::dataWidth-1:0] rtData,
	// pending destinations
	input logic [mipsPkg::regAddrWidth-1:0] exDest,
	input logic exRegWrite,
	input logic exMemRead,
	input logic [mipsPkg::regAddrWidth-1:0] memDest,
	input logic memRegWrite,
	// to fetch
	output logic stall,
	output logic redirect,
	output logic [mipsPkg::dataWidth-1:0] redirectPc,
	// decode/execute register
	output logic [mipsPkg::regAddrWidth-1:0] exRs,
	output logic [mipsPkg::regAddrWidth-1:0] exRt,
	output logic [mipsPkg::dataWidth-1:0] exRsVal,
	output logic [mipsPkg::dataWidth-1:0] exRtVal,
	output logic [mipsPkg::dataWidth-1:0] exImm,
	output logic [mipsPkg::dataWidth-1:0] exPcPlus4,
	output logic [mipsPkg::regAddrWidth-1:0] exRd,
	output mipsPkg::functT exFunct,
	output logic exAluSrc,
	output logic exIsRtype,
	output logic exIsLink,
	output logic exRegWriteOut,
	output logic exMemReadOut,
	output logic exMemWrite,
	output mipsPkg::wbSelT exWbSel
);

	mipsPkg::opcodeT opcode;
	mipsPkg::wbSelT wbSel;
	logic isRtype, isAddi, isLw, isSw, isBeq, isJ, isJal;
	logic usesRt;
	logic loadUse;
	logic branchWait;
	logic beqTaken;
	logic [mipsPkg::dataWidth-1:0] signImm;
	logic [mipsPkg::dataWidth-1:0] branchTarget;
	logic [mipsPkg::dataWidth-1:0] jumpTarget;

	assign opcode = mipsPkg::opcodeT'(idInstr[mipsPkg::opMsb:mipsPkg::opLsb]);
	assign rsAddr = idInstr[mipsPkg::rsMsb:mipsPkg::rsLsb];
	assign rtAddr = idInstr[mipsPkg::rtMsb:mipsPkg::rtLsb];

	//////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////
	always_comb begin
		isRtype = 1'b0;
		isAddi = 1'b0;
		isLw = 1'b0;
		isSw = 1'b0;
		isBeq = 1'b0;
		isJ = 1'b0;
		isJal = 1'b0;
		case (opcode)
			mipsPkg::opRtype: isRtype = 1'b1;
			mipsPkg::opAddi: isAddi = 1'b1;
			mipsPkg::opLw: isLw = 1'b1;
			mipsPkg::opSw: isSw = 1'b1;
			mipsPkg::opBeq: isBeq = 1'b1;
			mipsPkg::opJ: isJ = 1'b1;
			mipsPkg::opJal: isJal = 1'b1;
			// unknown opcode runs as a bubble
			default: isRtype = 1'b0;
		endcase
	end

	always_comb begin
		if (isLw) begin
			wbSel = mipsPkg::wbMem;
		end else if (isJal) begin
			wbSel = mipsPkg::wbLink;
		end else begin
			wbSel = mipsPkg::wbAlu;
		end
	end

	//////////////////////////////////////////////////
	// hazards and next pc
	//////////////////////////////////////////////////
	// rt is a source only for R-type, sw and beq
	assign usesRt = isRtype || isSw || isBeq;

	assign loadUse = exMemRead && (exDest != '0) &&
		(exDest == rsAddr || (usesRt && exDest == rtAddr));

	// beq compares here without forwarding, so wait out both later stages
	assign branchWait = isBeq && (
		(exRegWrite && exDest != '0 && (exDest == rsAddr || exDest == rtAddr)) ||
		(memRegWrite && memDest != '0 && (memDest == rsAddr || memDest == rtAddr)));

	assign stall = loadUse || branchWait;

	assign signImm = {{(mipsPkg::dataWidth-mipsPkg::immMsb-1){idInstr[mipsPkg::immMsb]}},
		idInstr[mipsPkg::immMsb:0]};
	assign branchTarget = idPcPlus4 + {signImm[mipsPkg::dataWidth-3:0], 2'b00};
	assign jumpTarget = {idPcPlus4[mipsPkg::dataWidth-1:mipsPkg::dataWidth-4],
		idInstr[mipsPkg::jumpIdxMsb:0], 2'b00};

	assign beqTaken = isBeq && (rsData == rtData);
	assign redirect = !stall && (beqTaken || isJ || isJal);
	assign redirectPc = beqTaken ? branchTarget : jumpTarget;

	//////////////////////////////////////////////////
	// decode/execute register
	//////////////////////////////////////////////////
	// a stall leaves a bubble behind in execute
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			exAluSrc <= 1'b0;
			exIsRtype <= 1'b0;
			exIsLink <= 1'b0;
			exRegWriteOut <= 1'b0;
			exMemReadOut <= 1'b0;
			exMemWrite <= 1'b0;
			exWbSel <= mipsPkg::wbAlu;
		end else begin
			exAluSrc <= !stall && (isAddi || isLw || isSw);
			exIsRtype <= !stall && isRtype;
			exIsLink <= !stall && isJal;
			exRegWriteOut <= !stall && (isRtype || isAddi || isLw || isJal);
			exMemReadOut <= !stall && isLw;
			exMemWrite <= !stall && isSw;
			exWbSel <= stall ? mipsPkg::wbAlu : wbSel;
		end
	end

	always_ff @(posedge clk) begin
		exRs <= rsAddr;
		exRt <= rtAddr;
		exRd <= idInstr[mipsPkg::rdMsb:mipsPkg::rdLsb];
		exRsVal <= rsData;
		exRtVal <= rtData;
		exImm <= signImm;
		exPcPlus4 <= idPcPlus4;
		exFunct <= mipsPkg::functT'(idInstr[mipsPkg::functMsb:0]);
	end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic reset,
	input logic [mipsPkg::regAddrWidth-1:0] rsAddr,
	input logic [mipsPkg::regAddrWidth-1:0] rtAddr,
	output logic [mipsPkg::dataWidth-1:0] rsData,
	output logic [mipsPkg::dataWidth-1:0] rtData,
	input logic wrEnable,
	input logic [mipsPkg::regAddrWidth-1:0] wrAddr,
	input logic [mipsPkg::dataWidth-1:0] wrData
);

	logic [mipsPkg::dataWidth-1:0] regs [mipsPkg::regCount];
	logic wrLive;

	// register 0 is hardwired to zero
	assign wrLive = wrEnable && (wrAddr != '0);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < mipsPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through so decode sees the word written this cycle
	assign rsData = (wrLive && wrAddr == rsAddr) ? wrData : regs[rsAddr];
	assign rtData = (wrLive && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

// ==== verilog/fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic redirect,
	input logic [mipsPkg::dataWidth-1:0] redirectPc,
	input logic [mipsPkg::dataWidth-1:0] instr,
	output logic [mipsPkg::dataWidth-1:0] instrAddr,
	output logic [mipsPkg::dataWidth-1:0] idInstr,
	output logic [mipsPkg::dataWidth-1:0] idPcPlus4
);

	logic [mipsPkg::dataWidth-1:0] pc;
	logic [mipsPkg::dataWidth-1:0] pcPlus4;

	assign instrAddr = pc;
	assign pcPlus4 = pc + mipsPkg::pcStep;

	// redirect squashes the slot fetched behind a branch or jump
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= mipsPkg::resetPc;
			idInstr <= mipsPkg::nopInstr;
		end else if (redirect) begin
			pc <= redirectPc;
			idInstr <= mipsPkg::nopInstr;
		end else if (!stall) begin
			pc <= pcPlus4;
			idInstr <= instr;
		end
	end

	// return address travels with its instruction
	always_ff @(posedge clk) begin
		if (!stall) begin
			idPcPlus4 <= pcPlus4;
		end
	end

endmodule

// ==== verilog/mipsPkg.sv ====
package mipsPkg;

	// widths and sizes
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;
	localparam int dmemWords = 64;
	localparam int dmemIndexWidth = 6;

	localparam logic [regAddrWidth-1:0] linkReg = 5'd31;
	localparam logic [dataWidth-1:0] pcStep = 32'd4;

	// values after reset, a zero word is also the nop
	localparam logic [dataWidth-1:0] resetPc = '0;
	localparam logic [dataWidth-1:0] nopInstr = '0;

	// instruction field positions
	localparam int opMsb = 31;
	localparam int opLsb = 26;
	localparam int rsMsb = 25;
	localparam int rsLsb = 21;
	localparam int rtMsb = 20;
	localparam int rtLsb = 16;
	localparam int rdMsb = 15;
	localparam int rdLsb = 11;
	localparam int immMsb = 15;
	localparam int functMsb = 5;
	localparam int jumpIdxMsb = 25;

	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opAddi = 6'h08,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluCtrlT;

	// source of the write-back word
	typedef enum logic [1:0] {
		wbAlu = 2'b00,
		wbMem = 2'b01,
		wbLink = 2'b10
	} wbSelT;

endpackage
